/* Bender.yml */
package:
  name: ctl_pipe0

sources:
  - hdl/usb_ctl_pkg.sv
  - hdl/ctl_request_fsm.sv
  - hdl/desc_byte_counter.sv
  - hdl/desc_rom.sv
  - hdl/device_state.sv
  - hdl/ctl_pipe0.sv
  - target: test
    files:
      - dv/tb_ctl_pipe0.sv

/* dv/tb_ctl_pipe0.sv */
`timescale 1ns/1ps
module tb_ctl_pipe0 import usb_ctl_pkg::*; ();

  localparam int NUM_RANDOM     = 150;
  localparam int NUM_REQ        = NUM_RANDOM + 5;  // directed requests run first
  localparam int TIMEOUT_CYCLES = NUM_REQ * 60 + 200;

  logic       clock;
  logic       reset;
  setup_req_t req_i;
  logic       req_valid_i;
  logic       req_ready_o;
  logic       status_i;
  byte_t      tdata_o;
  logic       tvalid_o;
  logic       tlast_o;
  logic       tready_i;
  logic       event_o;
  logic       error_o;
  usb_addr_t  usb_addr_o;
  conf_val_t  conf_o;
  logic       configured_o;

  logic [31:0] seed        = 32'hbd3792d1;
  int          cycle_count = 0;
  usb_addr_t   model_addr;
  conf_val_t   model_conf;
  setup_req_t  rand_req;
  string       rand_name;

  // device descriptor, byte 0 first, multi-byte fields little endian
  byte_t dev_bytes [18] = '{8'h12, 8'h01, 8'h00, 8'h02, 8'h00, 8'h00, 8'h00, 8'h40, 8'hce,
                            8'hf4, 8'h03, 8'h00, 8'h00, 8'h01, 8'h00, 8'h00, 8'h00, 8'h01};

  // config header, interface, bulk OUT ep1, bulk IN ep2
  byte_t cfg_bytes [32] = '{8'h09, 8'h02, 8'h20, 8'h00, 8'h01, 8'h01, 8'h00, 8'hc0, 8'h32,
                            8'h09, 8'h04, 8'h00, 8'h00, 8'h02, 8'h00, 8'h00, 8'h00, 8'h00,
                            8'h07, 8'h05, 8'h01, 8'h02, 8'h00, 8'h02, 8'h00,
                            8'h07, 8'h05, 8'h82, 8'h02, 8'h00, 8'h02, 8'h00};

  ctl_pipe0 dut (.*);

  always #4 clock = ~clock;

  always @(posedge clock) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      fail_stop("Timeout: the requests did not complete within the cycle limit");
    end
  end

  function automatic logic [31:0] lcg_next();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  function automatic int rand_below(input int n);
    return int'((lcg_next() >> 16) % n);  // upper bits are the better ones
  endfunction

  function automatic setup_req_t make_req(input byte_t code, input logic [15:0] value,
                                          input desc_len_t length);
    setup_req_t req;
    req.bm_request_type = (code == REQ_GET_DESCRIPTOR) ? 8'h80 : 8'h00;  // device to host
    req.b_request       = code;
    req.w_value         = value;
    req.w_index         = 16'h0000;
    req.w_length        = length;
    return req;
  endfunction

  task automatic fail_stop(input string msg);
    $display("%s", msg);
    $display("Simulation FAILED");
    $fatal(1);
  endtask

  task automatic check_byte(input string name, input byte_t exp, input byte_t act);
    if (act !== exp) begin
      fail_stop($sformatf("Mismatch %s: expected %0h, actual %0h", name, exp, act));
    end
  endtask

  task automatic check_addr(input string name, input usb_addr_t exp, input usb_addr_t act);
    if (act !== exp) begin
      fail_stop($sformatf("Mismatch %s: expected %0h, actual %0h", name, exp, act));
    end
  endtask

  task automatic check_conf(input string name, input conf_val_t exp, input conf_val_t act);
    if (act !== exp) begin
      fail_stop($sformatf("Mismatch %s: expected %0h, actual %0h", name, exp, act));
    end
  endtask

  task automatic check_flag(input string name, input bit exp, input bit act);
    if (act !== exp) begin
      fail_stop($sformatf("Mismatch %s: expected %0b, actual %0b", name, exp, act));
    end
  endtask

  task automatic run_request(input setup_req_t req, input string name);
    logic      expect_err;
    logic      use_cfg;
    int        len;
    int        n;
    usb_addr_t exp_addr;
    conf_val_t exp_conf;
    expect_err = 1'b0;
    use_cfg    = req.w_value[15:8] == 8'd2;
    len        = 0;
    exp_addr   = model_addr;
    exp_conf   = model_conf;
    if (req.b_request == REQ_GET_DESCRIPTOR) begin
      if (req.w_value[15:8] == 8'd1) begin
        len = (req.w_length < 18) ? int'(req.w_length) : 18;
      end else if (use_cfg) begin
        len = (req.w_length < 32) ? int'(req.w_length) : 32;
      end else begin
        expect_err = 1'b1;
      end
    end else if (req.b_request == REQ_SET_ADDRESS) begin
      exp_addr = req.w_value[6:0];
    end else if (req.b_request == REQ_SET_CONFIGURATION && req.w_value[7:0] <= 8'd1) begin
      exp_conf = req.w_value[7:0];
    end else begin
      expect_err = 1'b1;  // unknown code or illegal config value
    end
    if (rand_below(4) == 0) begin
      status_i = 1'b1;  // stray status in idle, must be ignored
      @(negedge clock);
      status_i = 1'b0;
    end
    check_flag({name, "/req_ready"}, 1'b1, req_ready_o);
    req_i       = req;
    req_valid_i = 1'b1;
    @(negedge clock);
    req_valid_i = 1'b0;
    req_i       = '0;
    check_flag({name, "/ready_low"}, 1'b0, req_ready_o);
    if (expect_err) begin
      @(negedge clock);
      check_flag({name, "/error"}, 1'b1, error_o);
      check_flag({name, "/tvalid"}, 1'b0, tvalid_o);
      check_flag({name, "/event"}, 1'b0, event_o);
      check_flag({name, "/ready_back"}, 1'b1, req_ready_o);
      @(negedge clock);
      check_flag({name, "/error_pulse"}, 1'b0, error_o);
    end else begin
      n = 0;
      while (n < len) begin
        if (tvalid_o) begin
          check_byte({name, "/tdata"}, use_cfg ? cfg_bytes[n] : dev_bytes[n], tdata_o);
          check_flag({name, "/tlast"}, n == len - 1, tlast_o);
        end
        check_flag({name, "/error"}, 1'b0, error_o);
        check_flag({name, "/event"}, 1'b0, event_o);
        tready_i = rand_below(4) != 0;  // stall one beat in four
        if (tvalid_o && tready_i) begin
          n++;
        end
        @(negedge clock);
      end
      tready_i = 1'b0;
      @(negedge clock);  // zero-data requests reach wait_status here
      check_flag({name, "/error"}, 1'b0, error_o);
      check_flag({name, "/tvalid_idle"}, 1'b0, tvalid_o);
      repeat (rand_below(8)) begin
        check_flag({name, "/event_early"}, 1'b0, event_o);
        check_flag({name, "/tvalid_idle"}, 1'b0, tvalid_o);
        @(negedge clock);
      end
      status_i = 1'b1;
      @(negedge clock);
      status_i = 1'b0;
      check_flag({name, "/event_early"}, 1'b0, event_o);
      check_addr({name, "/addr_early"}, model_addr, usb_addr_o);
      @(negedge clock);
      check_flag({name, "/event"}, 1'b1, event_o);
      check_flag({name, "/ready_back"}, 1'b1, req_ready_o);
      model_addr = exp_addr;
      model_conf = exp_conf;
    end
    check_addr({name, "/addr"}, model_addr, usb_addr_o);
    check_conf({name, "/conf"}, model_conf, conf_o);
    check_flag({name, "/configured"}, model_conf != '0, configured_o);
  endtask

  task automatic build_random(output setup_req_t req, output string name);
    int    kind;
    byte_t code;
    kind = rand_below(8);
    case (kind)
      0, 1: begin
        req  = make_req(REQ_GET_DESCRIPTOR, 16'h0100, desc_len_t'(rand_below(41)));
        name = "get_device";
      end
      2, 3: begin
        req  = make_req(REQ_GET_DESCRIPTOR, 16'h0200, desc_len_t'(rand_below(41)));
        name = "get_config";
      end
      4: begin
        req  = make_req(REQ_SET_ADDRESS, 16'(rand_below(256)), 16'd0);
        name = "set_address";
      end
      5: begin
        code = (rand_below(4) == 3) ? byte_t'(rand_below(256)) : byte_t'(rand_below(2));
        req  = make_req(REQ_SET_CONFIGURATION, {8'h00, code}, 16'd0);
        name = "set_config";
      end
      6: begin
        code = byte_t'(3 + rand_below(8));  // interface, endpoint and others
        req  = make_req(REQ_GET_DESCRIPTOR, {code, 8'h00}, desc_len_t'(rand_below(41)));
        name = "bad_desc_type";
      end
      default: begin
        code = byte_t'(rand_below(256));
        if (code == 8'd5 || code == 8'd6 || code == 8'd9) begin
          code = code + 8'd16;
        end
        req  = make_req(code, 16'(rand_below(65536)), 16'd0);
        name = "bad_request";
      end
    endcase
  endtask

  initial begin
    clock       = 1'b0;
    reset       = 1'b1;
    req_i       = '0;
    req_valid_i = 1'b0;
    status_i    = 1'b0;
    tready_i    = 1'b0;
    model_addr  = '0;
    model_conf  = '0;
    repeat (4) @(posedge clock);
    @(negedge clock);
    reset = 1'b0;
    check_addr("reset/addr", '0, usb_addr_o);
    check_conf("reset/conf", '0, conf_o);
    check_flag("reset/configured", 1'b0, configured_o);
    check_flag("reset/req_ready", 1'b1, req_ready_o);
    check_flag("reset/tvalid", 1'b0, tvalid_o);
    check_flag("reset/tlast", 1'b0, tlast_o);
    check_flag("reset/event", 1'b0, event_o);
    check_flag("reset/error", 1'b0, error_o);
    run_request(make_req(REQ_GET_DESCRIPTOR, 16'h0100, 16'd0), "get_device_zero_len");
    run_request(make_req(8'd8, 16'h0000, 16'd1), "get_configuration_unsupported");
    run_request(make_req(REQ_GET_DESCRIPTOR, 16'h0200, 16'd40), "get_config_full");
    run_request(make_req(REQ_SET_ADDRESS, 16'h00aa, 16'd0), "set_address_masked");
    run_request(make_req(REQ_SET_CONFIGURATION, 16'h0002, 16'd0), "set_config_invalid");
    for (int i = 0; i < NUM_RANDOM; i++) begin
      build_random(rand_req, rand_name);
      run_request(rand_req, rand_name);
    end
    $display("Simulation PASSED");
    $finish;
  end

endmodule

/* hdl/ctl_pipe0.sv */
`timescale 1ns/1ps
module ctl_pipe0 import usb_ctl_pkg::*; (
  input  logic       clock,
  input  logic       reset,
  input  setup_req_t req_i,
  input  logic       req_valid_i,
  output logic       req_ready_o,
  input  logic       status_i,
  output byte_t      tdata_o,
  output logic       tvalid_o,
  output logic       tlast_o,
  input  logic       tready_i,
  output logic       event_o,
  output logic       error_o,
  output usb_addr_t  usb_addr_o,
  output conf_val_t  conf_o,
  output logic       configured_o
);

  logic      cnt_load;
  logic      cnt_step;  // also the ROM fetch enable
  desc_len_t cnt_limit;
  desc_sel_t desc_sel;
  desc_idx_t next_idx;
  logic      conf_valid;
  logic      addr_write;
  usb_addr_t new_addr;
  logic      conf_write;
  conf_val_t new_conf;

  ctl_request_fsm u_fsm (
    .clock        (clock),
    .reset        (reset),
    .req_i        (req_i),
    .req_valid_i  (req_valid_i),
    .req_ready_o  (req_ready_o),
    .status_i     (status_i),
    .tready_i     (tready_i),
    .tvalid_o     (tvalid_o),
    .last_i       (tlast_o),
    .cnt_load_o   (cnt_load),
    .cnt_step_o   (cnt_step),
    .cnt_limit_o  (cnt_limit),
    .sel_o        (desc_sel),
    .conf_valid_i (conf_valid),
    .addr_write_o (addr_write),
    .addr_o       (new_addr),
    .conf_write_o (conf_write),
    .conf_val_o   (new_conf),
    .event_o      (event_o),
    .error_o      (error_o)
  );

  desc_byte_counter u_counter (
    .clock      (clock),
    .reset      (reset),
    .load_i     (cnt_load),
    .step_i     (cnt_step),
    .sel_i      (desc_sel),
    .limit_i    (cnt_limit),
    .next_idx_o (next_idx),
    .last_o     (tlast_o)
  );

  desc_rom u_rom (
    .clock   (clock),
    .sel_i   (desc_sel),
    .idx_i   (next_idx),
    .step_i  (cnt_step),
    .tdata_o (tdata_o)
  );

  device_state u_state (
    .clock        (clock),
    .reset        (reset),
    .addr_write_i (addr_write),
    .addr_i       (new_addr),
    .conf_write_i (conf_write),
    .conf_val_i   (new_conf),
    .conf_valid_o (conf_valid),
    .usb_addr_o   (usb_addr_o),
    .conf_o       (conf_o),
    .configured_o (configured_o)
  );

endmodule

/* hdl/ctl_request_fsm.sv */
`timescale 1ns/1ps
module ctl_request_fsm import usb_ctl_pkg::*; (
  input  logic       clock,
  input  logic       reset,
  input  setup_req_t req_i,
  input  logic       req_valid_i,
  output logic       req_ready_o,
  input  logic       status_i,
  input  logic       tready_i,
  output logic       tvalid_o,
  input  logic       last_i,
  output logic       cnt_load_o,
  output logic       cnt_step_o,
  output desc_len_t  cnt_limit_o,
  output desc_sel_t  sel_o,
  input  logic       conf_valid_i,
  output logic       addr_write_o,
  output usb_addr_t  addr_o,
  output logic       conf_write_o,
  output conf_val_t  conf_val_o,
  output logic       event_o,
  output logic       error_o
);

  ctl_state_t state_q;
  setup_req_t req_q;
  logic       pend_q;    // request latched, decode this cycle
  logic       fill_q;    // first byte being fetched from the ROM
  logic       tvalid_q;
  logic       event_q;
  logic       error_q;
  byte_t      desc_type;
  logic       accept;
  logic       beat;
  logic       is_get_desc;
  logic       is_set_addr;
  logic       is_set_conf;
  logic       type_ok;
  logic       bad_req;

  assign desc_type   = req_q.w_value[15:8];  // high byte of wValue
  assign is_get_desc = req_q.b_request == REQ_GET_DESCRIPTOR;
  assign is_set_addr = req_q.b_request == REQ_SET_ADDRESS;
  assign is_set_conf = req_q.b_request == REQ_SET_CONFIGURATION;
  assign type_ok     = (desc_type == DESC_TYPE_DEVICE) || (desc_type == DESC_TYPE_CONFIG);

  // anything the transaction layer has to STALL
  assign bad_req = !(is_get_desc || is_set_addr || is_set_conf) ||
                   (is_get_desc && !type_ok) ||
                   (is_set_conf && !conf_valid_i);

  assign req_ready_o = (state_q == st_idle) && !pend_q;
  assign accept      = req_valid_i && req_ready_o;
  assign beat        = tvalid_q && tready_i;

  // descriptor fetch control
  assign cnt_load_o  = (state_q == st_idle) && pend_q && !bad_req && is_get_desc &&
                       (req_q.w_length != '0);
  assign cnt_step_o  = (state_q == st_data_in) && (fill_q || beat);
  assign cnt_limit_o = req_q.w_length;
  assign sel_o       = (desc_type == DESC_TYPE_CONFIG) ? sel_config : sel_device;

  // device state updates land at the end of the status stage
  assign addr_o       = req_q.w_value[6:0];
  assign conf_val_o   = req_q.w_value[7:0];
  assign addr_write_o = (state_q == st_finish) && is_set_addr;
  assign conf_write_o = (state_q == st_finish) && is_set_conf;

  assign tvalid_o = tvalid_q;
  assign event_o  = event_q;
  assign error_o  = error_q;

  always_ff @(posedge clock) begin
    if (accept) begin
      req_q <= req_i;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      state_q  <= st_idle;
      pend_q   <= 1'b0;
      fill_q   <= 1'b0;
      tvalid_q <= 1'b0;
      event_q  <= 1'b0;
      error_q  <= 1'b0;
    end else begin
      event_q <= 1'b0;
      error_q <= 1'b0;
      pend_q  <= accept;
      case (state_q)
        st_idle: begin
          if (pend_q) begin
            if (bad_req) begin
              error_q <= 1'b1;  // stay in idle
            end else if (cnt_load_o) begin
              state_q <= st_data_in;
              fill_q  <= 1'b1;
            end else begin
              state_q <= st_wait_status;  // no data stage
            end
          end
        end
        st_data_in: begin
          if (fill_q) begin
            fill_q   <= 1'b0;
            tvalid_q <= 1'b1;
          end else if (beat && last_i) begin
            tvalid_q <= 1'b0;
            state_q  <= st_wait_status;
          end
        end
        st_wait_status: begin
          if (status_i) begin
            state_q <= st_finish;
          end
        end
        st_finish: begin
          event_q <= 1'b1;
          state_q <= st_idle;
        end
        default: state_q <= st_idle;
      endcase
    end
  end

  // a request ends either with an event or with a STALL
  assert property (@(posedge clock) disable iff (reset) !(event_o && error_o));

  assert property (@(posedge clock) disable iff (reset) tvalid_o |-> state_q == st_data_in);

endmodule

/* hdl/desc_byte_counter.sv */
`timescale 1ns/1ps
module desc_byte_counter import usb_ctl_pkg::*; (
  input  logic      clock,
  input  logic      reset,
  input  logic      load_i,
  input  logic      step_i,
  input  desc_sel_t sel_i,
  input  desc_len_t limit_i,
  output desc_idx_t next_idx_o,
  output logic      last_o
);

  desc_len_t desc_len;
  desc_idx_t count_q;  // clamped transfer length
  desc_idx_t idx_q;    // next byte to fetch
  desc_idx_t idx_inc;
  logic      last_q;

  assign desc_len = (sel_i == sel_config) ? CONFIG_TOTAL_LEN : DEVICE_DESC_LEN;
  assign idx_inc  = idx_q + 1'b1;

  assign next_idx_o = idx_q;
  assign last_o     = last_q;

  always_ff @(posedge clock) begin
    if (reset) begin
      count_q <= '0;
      idx_q   <= '0;
      last_q  <= 1'b0;
    end else if (load_i) begin
      // shorter of wLength and the descriptor
      if (limit_i < desc_len) begin
        count_q <= desc_idx_t'(limit_i);
      end else begin
        count_q <= desc_idx_t'(desc_len);
      end
      idx_q  <= '0;
      last_q <= 1'b0;
    end else if (step_i) begin
      if (idx_q != count_q) begin
        idx_q  <= idx_inc;
        last_q <= idx_inc == count_q;  // fetched byte is the final one
      end else begin
        last_q <= 1'b0;  // final byte consumed
      end
    end
  end

  // the fetch pointer stops at the clamped count
  assert property (@(posedge clock) disable iff (reset) idx_q <= count_q);

endmodule

/* hdl/desc_rom.sv */
`timescale 1ns/1ps
module desc_rom import usb_ctl_pkg::*; (
  input  logic      clock,
  input  desc_sel_t sel_i,
  input  desc_idx_t idx_i,
  input  logic      step_i,
  output byte_t     tdata_o
);

  logic [8*DEVICE_DESC_LEN-1:0]  dev_desc;
  logic [8*CONFIG_TOTAL_LEN-1:0] conf_desc;
  byte_t                         tdata_q;

  // byte 0 sits in the low bits, multi-byte fields little endian
  assign dev_desc = {
    NUM_CONFIGS,               // bNumConfigurations
    8'h00,                     // iSerialNumber
    8'h00,                     // iProduct
    8'h00,                     // iManufacturer
    DEVICE_RELEASE_BCD,        // bcdDevice
    PRODUCT_ID,                // idProduct
    VENDOR_ID,                 // idVendor
    MAX_PACKET_EP0,            // bMaxPacketSize0
    8'h00,                     // bDeviceProtocol
    8'h00,                     // bDeviceSubClass
    8'h00,                     // bDeviceClass
    USB_SPEC_BCD,              // bcdUSB
    DESC_TYPE_DEVICE,          // bDescriptorType
    byte_t'(DEVICE_DESC_LEN)   // bLength
  };

  // header, interface, then the two bulk endpoints
  assign conf_desc = {
    8'h00,                       // bInterval
    BULK_MAX_PACKET,             // wMaxPacketSize
    EP_ATTR_BULK,                // bmAttributes
    EP2_IN_ADDR,                 // bEndpointAddress
    DESC_TYPE_ENDPOINT,          // bDescriptorType
    byte_t'(ENDPOINT_DESC_LEN),  // bLength of EP2 IN
    8'h00,                       // bInterval
    BULK_MAX_PACKET,             // wMaxPacketSize
    EP_ATTR_BULK,                // bmAttributes
    EP1_OUT_ADDR,                // bEndpointAddress
    DESC_TYPE_ENDPOINT,          // bDescriptorType
    byte_t'(ENDPOINT_DESC_LEN),  // bLength of EP1 OUT
    8'h00,                       // iInterface
    8'h00,                       // bInterfaceProtocol
    8'h00,                       // bInterfaceSubClass
    8'h00,                       // bInterfaceClass
    NUM_ENDPOINTS,               // bNumEndpoints
    8'h00,                       // bAlternateSetting
    8'h00,                       // bInterfaceNumber
    DESC_TYPE_INTERFACE,         // bDescriptorType
    byte_t'(INTERFACE_DESC_LEN), // bLength of interface
    MAX_POWER_CODE,              // bMaxPower
    CONF_ATTRIBUTES,             // bmAttributes
    8'h00,                       // iConfiguration
    CONF_VALUE,                  // bConfigurationValue
    NUM_INTERFACES,              // bNumInterfaces
    CONFIG_TOTAL_LEN,            // wTotalLength
    DESC_TYPE_CONFIG,            // bDescriptorType
    byte_t'(CONFIG_HEADER_LEN)   // bLength of header
  };

  // output only moves on a fetch, so it holds under back-pressure
  always_ff @(posedge clock) begin
    if (step_i) begin
      if (sel_i == sel_config && idx_i < CONFIG_TOTAL_LEN) begin
        tdata_q <= conf_desc[idx_i*8 +: 8];
      end else if (sel_i == sel_device && idx_i < DEVICE_DESC_LEN) begin
        tdata_q <= dev_desc[idx_i*8 +: 8];
      end else begin
        tdata_q <= '0;  // past the end
      end
    end
  end

  assign tdata_o = tdata_q;

endmodule

/* hdl/device_state.sv */
`timescale 1ns/1ps
module device_state import usb_ctl_pkg::*; (
  input  logic      clock,
  input  logic      reset,
  input  logic      addr_write_i,
  input  usb_addr_t addr_i,
  input  logic      conf_write_i,
  input  conf_val_t conf_val_i,
  output logic      conf_valid_o,
  output usb_addr_t usb_addr_o,
  output conf_val_t conf_o,
  output logic      configured_o
);

  usb_addr_t addr_q;
  conf_val_t conf_q;

  // 0 drops back to the address state, CONF_VALUE configures
  assign conf_valid_o = (conf_val_i == '0) || (conf_val_i == CONF_VALUE);

  always_ff @(posedge clock) begin
    if (reset) begin
      addr_q <= '0;
      conf_q <= '0;
    end else begin
      // strobes only arrive after the status stage
      if (addr_write_i) begin
        addr_q <= addr_i;
      end
      if (conf_write_i) begin
        conf_q <= conf_val_i;
      end
    end
  end

  assign usb_addr_o   = addr_q;
  assign conf_o       = conf_q;
  assign configured_o = conf_q != '0;

  // the FSM stalls an illegal value before it ever writes
  assert property (@(posedge clock) disable iff (reset)
    (conf_o == '0) || (conf_o == CONF_VALUE));

endmodule

/* hdl/usb_ctl_pkg.sv */
package usb_ctl_pkg;

  // widths with a meaning on pipe 0
  typedef logic [7:0]  byte_t;      // one USB data byte
  typedef logic [6:0]  usb_addr_t;  // device address
  typedef logic [7:0]  conf_val_t;  // configuration value
  typedef logic [5:0]  desc_idx_t;  // byte index into a descriptor
  typedef logic [15:0] desc_len_t;  // descriptor or transfer length

  // decoded SETUP packet, bm_request_type in the top byte
  typedef struct packed {
    byte_t       bm_request_type;
    byte_t       b_request;
    logic [15:0] w_value;
    logic [15:0] w_index;
    desc_len_t   w_length;
  } setup_req_t;

  typedef enum logic {
    sel_device = 1'b0,
    sel_config = 1'b1
  } desc_sel_t;

  // control transfer sequencing
  typedef enum logic [2:0] {
    st_idle        = 3'd0,
    st_data_in     = 3'd1,  // streaming descriptor bytes
    st_wait_status = 3'd2,  // host status stage pending
    st_finish      = 3'd3   // single cycle, raises event
  } ctl_state_t;

  // standard request codes
  localparam byte_t REQ_SET_ADDRESS       = 8'd5;
  localparam byte_t REQ_GET_DESCRIPTOR    = 8'd6;
  localparam byte_t REQ_SET_CONFIGURATION = 8'd9;

  // descriptor type codes
  localparam byte_t DESC_TYPE_DEVICE    = 8'd1;
  localparam byte_t DESC_TYPE_CONFIG    = 8'd2;
  localparam byte_t DESC_TYPE_INTERFACE = 8'd4;
  localparam byte_t DESC_TYPE_ENDPOINT  = 8'd5;

  // descriptor lengths in bytes
  localparam desc_len_t DEVICE_DESC_LEN    = 16'd18;
  localparam desc_len_t CONFIG_HEADER_LEN  = 16'd9;
  localparam desc_len_t INTERFACE_DESC_LEN = 16'd9;
  localparam desc_len_t ENDPOINT_DESC_LEN  = 16'd7;

  // header + interface + two bulk endpoints = 32
  localparam desc_len_t CONFIG_TOTAL_LEN =
      CONFIG_HEADER_LEN + INTERFACE_DESC_LEN + 16'd2 * ENDPOINT_DESC_LEN;

  // device identification
  localparam logic [15:0] USB_SPEC_BCD       = 16'h0200;  // USB 2.0
  localparam logic [15:0] DEVICE_RELEASE_BCD = 16'h0100;
  localparam logic [15:0] VENDOR_ID          = 16'hF4CE;
  localparam logic [15:0] PRODUCT_ID         = 16'h0003;
  localparam byte_t       NUM_CONFIGS        = 8'd1;

  // packet sizes
  localparam byte_t       MAX_PACKET_EP0  = 8'd64;
  localparam logic [15:0] BULK_MAX_PACKET = 16'd512;  // high-speed bulk

  // bulk endpoints
  localparam byte_t EP1_OUT_ADDR  = 8'h01;
  localparam byte_t EP2_IN_ADDR   = 8'h82;  // direction bit set for IN
  localparam byte_t EP_ATTR_BULK  = 8'h02;
  localparam byte_t NUM_ENDPOINTS = 8'd2;

  // configuration header fields
  localparam byte_t     NUM_INTERFACES  = 8'd1;
  localparam conf_val_t CONF_VALUE      = 8'd1;   // only non-zero config
  localparam byte_t     MAX_POWER_CODE  = 8'h32;  // 2 mA units
  localparam byte_t     CONF_ATTRIBUTES = 8'hC0;  // self-powered

endpackage

/* vlog.f */
hdl/usb_ctl_pkg.sv
hdl/ctl_request_fsm.sv
hdl/desc_byte_counter.sv
hdl/desc_rom.sv
hdl/device_state.sv
hdl/ctl_pipe0.sv
dv/tb_ctl_pipe0.sv
